// ==== bench/udp_mux_stimulus.txt ====
# F <source> <udp dest port hex> <udp length hex> <beats> then per beat <byte hex> <user>
# E <frame count> then the source of each output frame in order
F 0 0035 000c 4 a0 0 a1 0 a2 0 a3 0
F 1 1f90 000a 2 b0 0 b1 1
F 2 0044 0009 1 c0 0
F 3 0d3d 000b 3 d0 0 d1 0 d2 0
F 0 0035 0009 1 a4 1
F 1 1f91 000d 5 b2 0 b3 0 b4 0 b5 0 b6 0
F 2 0044 000b 3 c1 0 c2 0 c3 1
F 3 0d3d 0009 1 d3 0
F 0 0036 000b 3 a5 0 a6 0 a7 0
F 1 1f92 0009 1 b7 0
F 2 0045 0009 1 c4 0
F 3 0d3e 000c 4 d4 0 d5 1 d6 0 d7 0
F 0 0037 0009 1 a8 0
F 2 0046 000e 6 c5 0 c6 0 c7 0 c8 0 c9 0 ca 1
F 3 0d3f 000a 2 d8 0 d9 0
F 0 0038 000a 2 a9 0 aa 0
F 2 0047 000a 2 cb 0 cc 0
F 2 0048 0009 1 cd 0
# round robin with every source loaded, empty sources skipped
E 18 0 1 2 3 0 1 2 3 0 1 2 3 0 2 3 0 2 2

// ==== list.f ====
hdl/udp_mux_pkg.sv
hdl/udp_rr_arbiter.sv
hdl/udp_frame_tracker.sv
hdl/udp_hdr_stage.sv
hdl/udp_payload_path.sv
hdl/udp_arb_mux.sv
bench/tb_udp_arb_mux.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the multiplexer testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f list.f --top-module tb_udp_arb_mux -o tb_udp_arb_mux \
    && ./obj_dir/tb_udp_arb_mux \
    || { echo "build or simulation did not succeed"; exit 1; }

// ==== bench/tb_udp_arb_mux.sv ====
/*
 * Testbench for the UDP frame multiplexer
 * four sources replay the stimulus file frames, output frames are checked in order
 */
`timescale 1ns/10ps

module tb_udp_arb_mux;

    localparam int S_COUNT = 4;
    localparam int MAXF = 24;
    localparam int MAXB = 16;

    logic                   clk;
    logic                   rst;
    logic [S_COUNT-1:0]     hdr_valid;
    udp_mux_pkg::udp_hdr_t  hdr [S_COUNT];
    logic [S_COUNT-1:0]     hdr_ready;
    logic [S_COUNT-1:0]     pay_valid;
    udp_mux_pkg::udp_beat_t pay [S_COUNT];
    logic [S_COUNT-1:0]     pay_ready;
    logic                   m_hdr_valid;
    udp_mux_pkg::udp_hdr_t  m_hdr;
    logic                   m_hdr_ready;
    logic                   m_pay_valid;
    udp_mux_pkg::udp_beat_t m_pay;
    logic                   m_pay_ready;

    // frames in file order
    int          frm_src [MAXF];
    logic [15:0] frm_dport [MAXF];
    logic [15:0] frm_len [MAXF];
    int          frm_nb [MAXF];
    logic [7:0]  frm_byte [MAXF][MAXB];
    logic        frm_user [MAXF][MAXB];
    int          n_frames;
    int          total_beats;
    int          src_frames [S_COUNT][MAXF];
    int          src_count [S_COUNT];
    // frame number of each output frame
    int          exp_frame [MAXF];
    int          n_exp;
    int          hdr_ptr [S_COUNT];
    int          pay_ptr [S_COUNT];
    int          beat_ptr [S_COUNT];
    int          hdr_out;
    int          pay_out;
    int          out_beat;
    logic        loaded;

    udp_arb_mux #(.S_COUNT(S_COUNT)) u_udp_arb_mux (
        .clk(clk), .rst(rst),
        .hdr_valid(hdr_valid), .hdr(hdr), .hdr_ready(hdr_ready),
        .pay_valid(pay_valid), .pay(pay), .pay_ready(pay_ready),
        .m_hdr_valid(m_hdr_valid), .m_hdr(m_hdr), .m_hdr_ready(m_hdr_ready),
        .m_pay_valid(m_pay_valid), .m_pay(m_pay), .m_pay_ready(m_pay_ready)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare_hdr(input string name, input udp_mux_pkg::udp_hdr_t exp_val,
                               input udp_mux_pkg::udp_hdr_t act_val);
        if (act_val !== exp_val) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp_val, act_val);
            report_failure("output header differs from the expected frame header");
        end
    endtask

    task automatic compare_beat(input string name, input udp_mux_pkg::udp_beat_t exp_val,
                                input udp_mux_pkg::udp_beat_t act_val);
        if (act_val !== exp_val) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp_val, act_val);
            report_failure("output payload beat differs from the expected beat");
        end
    endtask

    task automatic compare_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp_val, act_val);
            report_failure("output handshake flag has the wrong level");
        end
    endtask

    // full header from the file fields plus a fill that depends on the frame number
    function automatic udp_mux_pkg::udp_hdr_t build_hdr(input int f);
        udp_mux_pkg::udp_hdr_t h;
        h.eth_dest_mac = 48'h0200_0000_0000 + 48'(f);
        h.eth_src_mac = 48'h0200_0000_0100 + 48'(frm_src[f]);
        h.eth_type = 16'h0800;
        h.ip_version = 4'd4;
        h.ip_ihl = 4'd5;
        h.ip_dscp = 6'(f);
        h.ip_ecn = 2'(frm_src[f]);
        h.ip_length = frm_len[f] + 16'd20;
        h.ip_identification = 16'h1000 + 16'(f);
        h.ip_flags = 3'b010;
        h.ip_fragment_offset = 13'(f * 3);
        h.ip_ttl = 8'd64;
        h.ip_protocol = 8'd17;
        h.ip_header_checksum = 16'hbe00 ^ 16'(f);
        h.ip_source_ip = 32'hc0a8_0100 + 32'(frm_src[f]);
        h.ip_dest_ip = 32'hc0a8_0200 + 32'(f);
        h.udp_source_port = 16'h4000 + 16'(f);
        h.udp_dest_port = frm_dport[f];
        h.udp_length = frm_len[f];
        h.udp_checksum = 16'h5a00 ^ 16'(f);
        return h;
    endfunction

    function automatic udp_mux_pkg::udp_beat_t build_beat(input int f, input int k);
        udp_mux_pkg::udp_beat_t bt;
        bt.data = frm_byte[f][k];
        bt.last = (k == frm_nb[f] - 1);
        bt.user = frm_user[f][k];
        return bt;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          c;
        int          rc;
        int          s;
        int          nb;
        int          u;
        int          occ [S_COUNT];
        logic [7:0]  ch;
        logic [7:0]  b;
        logic [15:0] dport;
        logic [15:0] len;
        logic [8*128-1:0] line;
        n_frames = 0;
        total_beats = 0;
        n_exp = 0;
        for (int i = 0; i < S_COUNT; i++) begin
            src_count[i] = 0;
            occ[i] = 0;
        end
        fd = $fopen("bench/udp_mux_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open the stimulus file bench/udp_mux_stimulus.txt");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            ch = c[7:0];
            if (ch == "#") begin
                rc = $fgets(line, fd);
            end else if (ch == "F") begin
                rc = $fscanf(fd, "%d %h %h %d", s, dport, len, nb);
                if (rc != 4 || n_frames >= MAXF || nb < 1 || nb > MAXB || s >= S_COUNT) begin
                    report_failure("malformed frame line in the stimulus file");
                end
                frm_src[n_frames] = s;
                frm_dport[n_frames] = dport;
                frm_len[n_frames] = len;
                frm_nb[n_frames] = nb;
                for (int k = 0; k < nb; k++) begin
                    rc = $fscanf(fd, "%h %d", b, u);
                    frm_byte[n_frames][k] = b;
                    frm_user[n_frames][k] = u[0];
                end
                src_frames[s][src_count[s]] = n_frames;
                src_count[s]++;
                total_beats += nb;
                n_frames++;
            end else if (ch == "E") begin
                rc = $fscanf(fd, "%d", n_exp);
                if (n_exp > MAXF) begin
                    report_failure("expected order lists more frames than the testbench holds");
                end
                for (int n = 0; n < n_exp; n++) begin
                    rc = $fscanf(fd, "%d", s);
                    if (s >= S_COUNT || occ[s] >= src_count[s]) begin
                        report_failure("expected order names a frame that no source holds");
                    end
                    exp_frame[n] = src_frames[s][occ[s]];
                    occ[s]++;
                end
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (n_exp != n_frames || n_frames == 0) begin
            report_failure("expected order does not cover every frame of the file");
        end
    endtask

    task automatic drive_inputs();
        int f;
        for (int s = 0; s < S_COUNT; s++) begin
            hdr_valid[s] = hdr_ptr[s] < src_count[s];
            if (hdr_valid[s]) begin
                hdr[s] = build_hdr(src_frames[s][hdr_ptr[s]]);
            end
            pay_valid[s] = pay_ptr[s] < src_count[s];
            if (pay_valid[s]) begin
                f = src_frames[s][pay_ptr[s]];
                pay[s] = build_beat(f, beat_ptr[s]);
            end
        end
        m_hdr_ready = ($urandom % 4) != 0;
        m_pay_ready = ($urandom % 3) != 0;
    endtask

    // values seen here are the ones the next rising edge takes
    task automatic sample_transfers();
        udp_mux_pkg::udp_beat_t exp_beat;
        for (int s = 0; s < S_COUNT; s++) begin
            if (hdr_valid[s] && hdr_ready[s]) begin
                hdr_ptr[s]++;
            end
            if (pay_valid[s] && pay_ready[s]) begin
                if (pay[s].last) begin
                    beat_ptr[s] = 0;
                    pay_ptr[s]++;
                end else begin
                    beat_ptr[s]++;
                end
            end
        end
        if (m_hdr_valid && m_hdr_ready) begin
            if (hdr_out >= n_exp) begin
                report_failure("a header left the DUT after the last expected frame");
            end
            compare_hdr("m_hdr", build_hdr(exp_frame[hdr_out]), m_hdr);
            hdr_out++;
        end
        if (m_pay_valid && m_pay_ready) begin
            if (pay_out >= n_exp) begin
                report_failure("a payload beat left the DUT after the last expected frame");
            end
            exp_beat = build_beat(exp_frame[pay_out], out_beat);
            compare_beat("m_pay", exp_beat, m_pay);
            if (exp_beat.last) begin
                pay_out++;
                out_beat = 0;
            end else begin
                out_beat++;
            end
        end
    endtask

    function automatic logic sources_drained();
        logic ok;
        ok = 1'b1;
        for (int s = 0; s < S_COUNT; s++) begin
            if (hdr_ptr[s] != src_count[s] || pay_ptr[s] != src_count[s]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        wait (loaded);
        repeat (40 * total_beats + 200) @(posedge clk);
        report_failure("timeout: the expected frames did not all leave the DUT in time");
    end

    initial begin
        rst = 1'b1;
        loaded = 1'b0;
        hdr_valid = '0;
        pay_valid = '0;
        m_hdr_ready = 1'b0;
        m_pay_ready = 1'b0;
        for (int s = 0; s < S_COUNT; s++) begin
            hdr[s] = '0;
            pay[s] = '0;
            hdr_ptr[s] = 0;
            pay_ptr[s] = 0;
            beat_ptr[s] = 0;
        end
        hdr_out = 0;
        pay_out = 0;
        out_beat = 0;
        void'($urandom(73358));
        load_stimulus();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
        compare_flag("m_hdr_valid", 1'b0, m_hdr_valid);
        compare_flag("m_pay_valid", 1'b0, m_pay_valid);
        drive_inputs();
        while (hdr_out < n_exp || pay_out < n_exp) begin
            @(negedge clk);
            sample_transfers();
            @(posedge clk);
            #5;
            drive_inputs();
        end
        if (sources_drained()) begin
            $display("sim passed");
            $finish;
        end else begin
            report_failure("output is complete but a source still holds unsent data");
        end
    end

endmodule

// ==== hdl/udp_arb_mux.sv ====
/*
 * UDP arbitrated frame multiplexer
 * round-robin selection of S_COUNT header and payload sources onto one output
 */
`timescale 1ns/10ps

module udp_arb_mux #(
    parameter int S_COUNT = 4
) (
    input  logic                   clk,
    input  logic                   rst,

    // source side
    input  logic [S_COUNT-1:0]     hdr_valid,
    input  udp_mux_pkg::udp_hdr_t  hdr [S_COUNT],
    output logic [S_COUNT-1:0]     hdr_ready,
    input  logic [S_COUNT-1:0]     pay_valid,
    input  udp_mux_pkg::udp_beat_t pay [S_COUNT],
    output logic [S_COUNT-1:0]     pay_ready,

    // output side
    output logic                   m_hdr_valid,
    output udp_mux_pkg::udp_hdr_t  m_hdr,
    input  logic                   m_hdr_ready,
    output logic                   m_pay_valid,
    output udp_mux_pkg::udp_beat_t m_pay,
    input  logic                   m_pay_ready
);

    localparam int IDX_W = $clog2(S_COUNT);

    logic [S_COUNT-1:0] grant;
    logic               grant_valid;
    logic [IDX_W-1:0]   grant_index;
    logic [S_COUNT-1:0] acknowledge;
    logic [S_COUNT-1:0] hdr_fire;
    logic [S_COUNT-1:0] last_fire;

    // a pending header is the request
    udp_rr_arbiter #(.S_COUNT(S_COUNT)) u_arbiter (
        .clk(clk), .rst(rst),
        .request(hdr_valid), .acknowledge(acknowledge),
        .grant(grant), .grant_valid(grant_valid), .grant_index(grant_index)
    );

    udp_frame_tracker #(.S_COUNT(S_COUNT)) u_tracker (
        .clk(clk), .rst(rst),
        .grant(grant), .hdr_fire(hdr_fire), .last_fire(last_fire),
        .acknowledge(acknowledge)
    );

    udp_hdr_stage #(.S_COUNT(S_COUNT)) u_hdr_stage (
        .clk(clk), .rst(rst),
        .grant(grant), .grant_valid(grant_valid), .grant_index(grant_index),
        .hdr_valid(hdr_valid), .hdr(hdr), .hdr_ready(hdr_ready),
        .last_fire(last_fire),
        .m_hdr_valid(m_hdr_valid), .m_hdr(m_hdr), .m_hdr_ready(m_hdr_ready),
        .hdr_fire(hdr_fire)
    );

    udp_payload_path #(.S_COUNT(S_COUNT)) u_payload_path (
        .clk(clk), .rst(rst),
        .grant_valid(grant_valid), .grant_index(grant_index),
        .pay_valid(pay_valid), .pay(pay), .pay_ready(pay_ready),
        .m_pay_valid(m_pay_valid), .m_pay(m_pay), .m_pay_ready(m_pay_ready),
        .last_fire(last_fire)
    );

endmodule

// ==== hdl/udp_payload_path.sv ====
/*
 * Payload path
 * granted lane select feeding a two-entry skid buffer with registered ready
 */
`timescale 1ns/10ps

module udp_payload_path #(
    parameter int S_COUNT = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       grant_valid,
    input  logic [$clog2(S_COUNT)-1:0] grant_index,
    input  logic [S_COUNT-1:0]         pay_valid,
    input  udp_mux_pkg::udp_beat_t     pay [S_COUNT],
    output logic [S_COUNT-1:0]         pay_ready,
    output logic                       m_pay_valid,
    output udp_mux_pkg::udp_beat_t     m_pay,
    input  logic                       m_pay_ready,
    output logic [S_COUNT-1:0]         last_fire
);

    localparam int IDX_W = $clog2(S_COUNT);

    udp_mux_pkg::udp_beat_t cur_beat;
    udp_mux_pkg::udp_beat_t temp_beat;

    logic             ready_int_reg;
    logic             ready_int_early;
    logic             valid_int;
    logic             lane_open;
    logic             done;
    logic [IDX_W-1:0] done_index;
    logic             temp_valid;
    logic             m_valid_next;
    logic             temp_valid_next;
    logic             store_out;
    logic             store_temp;
    logic             temp_to_out;

    assign cur_beat = pay[grant_index];

    // lane closes after its last beat until the grant moves on
    assign lane_open = grant_valid && !(done && grant_index == done_index);

    assign pay_ready = S_COUNT'(ready_int_reg && lane_open) << grant_index;
    assign valid_int = pay_valid[grant_index] && ready_int_reg && lane_open;

    assign ready_int_early = (m_pay_ready || (!temp_valid && !m_pay_valid)) && grant_valid;

    always_comb begin
        for (int i = 0; i < S_COUNT; i++) begin
            last_fire[i] = pay_valid[i] && pay_ready[i] && pay[i].last;
        end
    end

    always_comb begin
        m_valid_next = m_pay_valid;
        temp_valid_next = temp_valid;
        store_out = 1'b0;
        store_temp = 1'b0;
        temp_to_out = 1'b0;
        if (ready_int_reg) begin
            if (m_pay_ready || !m_pay_valid) begin
                m_valid_next = valid_int;
                store_out = 1'b1;
            end else begin
                // output stalled, park the beat in the skid entry
                temp_valid_next = valid_int;
                store_temp = 1'b1;
            end
        end else if (m_pay_ready) begin
            m_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_pay_valid <= 1'b0;
            temp_valid <= 1'b0;
            ready_int_reg <= 1'b0;
            done <= 1'b0;
            done_index <= '0;
        end else begin
            m_pay_valid <= m_valid_next;
            temp_valid <= temp_valid_next;
            ready_int_reg <= ready_int_early;
            if (|last_fire) begin
                done <= 1'b1;
                done_index <= grant_index;
            end else if (!grant_valid || grant_index != done_index) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_out) begin
            m_pay <= cur_beat;
        end else if (temp_to_out) begin
            m_pay <= temp_beat;
        end
        if (store_temp) begin
            temp_beat <= cur_beat;
        end
    end

    a_temp_not_full: assert property (@(posedge clk) disable iff (rst)
        store_temp |-> !temp_valid);

endmodule

// ==== hdl/udp_hdr_stage.sv ====
/*
 * Header stage
 * takes one header from the granted source into the output header register
 */
`timescale 1ns/10ps

module udp_hdr_stage #(
    parameter int S_COUNT = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [S_COUNT-1:0]         grant,
    input  logic                       grant_valid,
    input  logic [$clog2(S_COUNT)-1:0] grant_index,
    input  logic [S_COUNT-1:0]         hdr_valid,
    input  udp_mux_pkg::udp_hdr_t      hdr [S_COUNT],
    output logic [S_COUNT-1:0]         hdr_ready,
    input  logic [S_COUNT-1:0]         last_fire,
    output logic                       m_hdr_valid,
    output udp_mux_pkg::udp_hdr_t      m_hdr,
    input  logic                       m_hdr_ready,
    output logic [S_COUNT-1:0]         hdr_fire
);

    logic frame;
    logic last_seen;
    logic last_hit;
    logic issue;

    assign last_hit = |(last_fire & grant);

    // no second pulse while one is in flight, output register free or draining
    assign issue = grant_valid && !frame && !(|hdr_ready) && (m_hdr_ready || !m_hdr_valid);

    assign hdr_fire = hdr_valid & hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame <= 1'b0;
            last_seen <= 1'b0;
            hdr_ready <= '0;
            m_hdr_valid <= 1'b0;
        end else begin
            hdr_ready <= issue ? grant : '0;
            if (issue) begin
                m_hdr_valid <= 1'b1;
                // frame already ended if its last beat went first
                frame <= !(last_seen || last_hit);
                last_seen <= 1'b0;
            end else begin
                if (m_hdr_ready) begin
                    m_hdr_valid <= 1'b0;
                end
                if (last_hit) begin
                    frame <= 1'b0;
                    last_seen <= last_seen || !frame;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            m_hdr <= hdr[grant_index];
        end
    end

    a_hdr_stable: assert property (@(posedge clk) disable iff (rst)
        (m_hdr_valid && !m_hdr_ready) |=> $stable(m_hdr));

endmodule

// ==== hdl/udp_frame_tracker.sv ====
/*
 * Frame completion tracker
 * acknowledges the grant once both header and last payload beat are taken
 */
`timescale 1ns/10ps

module udp_frame_tracker #(
    parameter int S_COUNT = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [S_COUNT-1:0] grant,
    input  logic [S_COUNT-1:0] hdr_fire,
    input  logic [S_COUNT-1:0] last_fire,
    output logic [S_COUNT-1:0] acknowledge
);

    udp_mux_pkg::trk_state_t state;
    udp_mux_pkg::trk_state_t state_next;

    logic hdr_hit;
    logic last_hit;
    logic done;

    // only events of the granted source count
    assign hdr_hit = |(hdr_fire & grant);
    assign last_hit = |(last_fire & grant);

    always_comb begin
        state_next = state;
        done = 1'b0;
        case (state)
            udp_mux_pkg::TRK_OPEN: begin
                if (hdr_hit && last_hit) begin
                    // both in one cycle, release at once
                    done = 1'b1;
                end else if (hdr_hit) begin
                    state_next = udp_mux_pkg::TRK_HDR_DONE;
                end else if (last_hit) begin
                    // single beat frame overtaking its header
                    state_next = udp_mux_pkg::TRK_LAST_DONE;
                end
            end
            udp_mux_pkg::TRK_HDR_DONE: begin
                if (last_hit) begin
                    done = 1'b1;
                    state_next = udp_mux_pkg::TRK_OPEN;
                end
            end
            udp_mux_pkg::TRK_LAST_DONE: begin
                if (hdr_hit) begin
                    done = 1'b1;
                    state_next = udp_mux_pkg::TRK_OPEN;
                end
            end
            default: state_next = udp_mux_pkg::TRK_OPEN;
        endcase
    end

    assign acknowledge = done ? grant : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_mux_pkg::TRK_OPEN;
        end else begin
            state <= state_next;
        end
    end

    // each completion event happens once per granted frame
    a_no_double_hdr: assert property (@(posedge clk) disable iff (rst)
        (state == udp_mux_pkg::TRK_HDR_DONE) |-> !hdr_hit);
    a_no_double_last: assert property (@(posedge clk) disable iff (rst)
        (state == udp_mux_pkg::TRK_LAST_DONE) |-> !last_hit);

endmodule

// ==== hdl/udp_rr_arbiter.sv ====
/*
 * Round-robin arbiter for the UDP frame multiplexer
 * grant is registered and held until the granted source is acknowledged
 */
`timescale 1ns/10ps

module udp_rr_arbiter #(
    parameter int S_COUNT = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [S_COUNT-1:0]         request,
    input  logic [S_COUNT-1:0]         acknowledge,
    output logic [S_COUNT-1:0]         grant,
    output logic                       grant_valid,
    output logic [$clog2(S_COUNT)-1:0] grant_index
);

    localparam int IDX_W = $clog2(S_COUNT);

    logic [S_COUNT-1:0] grant_del;
    logic [S_COUNT-1:0] masked;
    logic [IDX_W-1:0]   cand;
    logic [IDX_W-1:0]   pick_index;
    logic               found;
    logic               hold;

    // a source is not requested while held or in the cycle after its grant drops
    assign masked = request & ~grant & ~grant_del;

    assign hold = grant_valid && !(|(grant & acknowledge));

    // search starts just after the last granted index
    always_comb begin
        found = 1'b0;
        pick_index = '0;
        cand = '0;
        for (int k = 1; k <= S_COUNT; k++) begin
            cand = IDX_W'((int'(grant_index) + k) % S_COUNT);
            if (!found && masked[cand]) begin
                found = 1'b1;
                pick_index = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
            grant_valid <= 1'b0;
            grant_del <= '0;
            // lowest index wins first after reset
            grant_index <= IDX_W'(S_COUNT - 1);
        end else begin
            grant_del <= grant;
            if (hold) begin
                grant <= grant;
            end else if (found) begin
                grant <= S_COUNT'(1) << pick_index;
                grant_valid <= 1'b1;
                grant_index <= pick_index;
            end else begin
                // index is kept as the rotation point
                grant <= '0;
                grant_valid <= 1'b0;
            end
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

endmodule

// ==== hdl/udp_mux_pkg.sv ====
/*
 * UDP frame multiplexer shared types
 * header bundle, payload beat and the frame tracker states
 */
package udp_mux_pkg;

    // one byte per payload beat
    localparam int PAYLOAD_WIDTH = 8;

    // ethernet, ipv4 and udp header fields, 336 bits in total
    typedef struct packed {
        // ethernet
        logic [47:0] eth_dest_mac;
        logic [47:0] eth_src_mac;
        logic [15:0] eth_type;
        // ipv4
        logic [3:0]  ip_version;
        logic [3:0]  ip_ihl;
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [15:0] ip_length;
        logic [15:0] ip_identification;
        logic [2:0]  ip_flags;
        logic [12:0] ip_fragment_offset;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_protocol;
        logic [15:0] ip_header_checksum;
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        // udp
        logic [15:0] udp_source_port;
        logic [15:0] udp_dest_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
    } udp_hdr_t;

    // one payload beat
    typedef struct packed {
        logic [PAYLOAD_WIDTH-1:0] data;
        // marks the final beat of a frame
        logic                     last;
        // frame error flag
        logic                     user;
    } udp_beat_t;

    // completion progress of the granted frame
    typedef enum logic [1:0] {
        // neither header nor last beat accepted yet
        TRK_OPEN      = 2'd0,
        // header accepted, waiting for the last beat
        TRK_HDR_DONE  = 2'd1,
        // last beat accepted before the header
        TRK_LAST_DONE = 2'd2
    } trk_state_t;

endpackage
